// File: Makefile
# Verilator build and run of the partial-write subsystem testbench

VERILATOR ?= verilator
TOP ?= tb_strb_subsys
FILELIST ?= all.f
OBJ_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert -Wno-fatal
TESTS ?= tb/strb_tests.txt

BIN := $(OBJ_DIR)/V$(TOP)
SRCS := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN) $(TESTS)
	./$(BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "^Done: no errors$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: all.f
hdl/strb_pkg.sv
hdl/strbreq_handler.sv
hdl/reqrsp_arbiter.sv
hdl/word_mem.sv
hdl/strb_subsys_top.sv
tb/tb_clkgen.sv
tb/tb_strb_subsys.sv

// File: hdl/reqrsp_arbiter.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Round-robin merge of two request ports onto one
// Responses are routed back by user.port, not by grant history
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns

module reqrsp_arbiter (
	input logic clk_i,
	input logic arst_n_i,
	input strb_pkg::mem_req_t in0_req_i,
	input strb_pkg::mem_req_t in1_req_i,
	output strb_pkg::mem_rsp_t in0_rsp_o,
	output strb_pkg::mem_rsp_t in1_rsp_o,
	output strb_pkg::mem_req_t out_req_o,
	input strb_pkg::mem_rsp_t out_rsp_i
);

	// Port that won the last transfer
	logic last_q;
	// Grant frozen while a granted request is stalled
	logic lock_q;
	logic sel_q;
	// Current grant, 1 means port 1
	logic sel;
	// Response destination
	logic rsp_sel;
	logic out_xfer;

	always_comb begin
		if (lock_q) begin
			sel = sel_q;
		end else if (in0_req_i.q_valid && in1_req_i.q_valid) begin
			// Tie goes to the port that lost last time
			sel = ~last_q;
		end else begin
			sel = in1_req_i.q_valid;
		end
	end

	assign rsp_sel = out_rsp_i.p.user.port;

	// Request path follows the grant
	assign out_req_o.q = sel ? in1_req_i.q : in0_req_i.q;
	assign out_req_o.q_valid = sel ? in1_req_i.q_valid : in0_req_i.q_valid;
	// Response ready comes from the port the response belongs to
	assign out_req_o.p_ready = rsp_sel ? in1_req_i.p_ready : in0_req_i.p_ready;

	assign out_xfer = out_req_o.q_valid && out_rsp_i.q_ready;

	// Port 0 side
	assign in0_rsp_o.p = out_rsp_i.p;
	assign in0_rsp_o.p_valid = out_rsp_i.p_valid && !rsp_sel;
	assign in0_rsp_o.q_ready = out_rsp_i.q_ready && !sel;

	// Port 1 side
	assign in1_rsp_o.p = out_rsp_i.p;
	assign in1_rsp_o.p_valid = out_rsp_i.p_valid && rsp_sel;
	assign in1_rsp_o.q_ready = out_rsp_i.q_ready && sel;

	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			// Port 0 wins the first tie
			last_q <= 1'b1;
			lock_q <= 1'b0;
			sel_q <= 1'b0;
		end else begin
			if (out_xfer) begin
				last_q <= sel;
			end
			// Lock only on a stalled valid
			lock_q <= out_req_o.q_valid && !out_rsp_i.q_ready;
			sel_q <= sel;
		end
	end

	// Stalled request is neither dropped nor changed by the grant
	assert property (@(posedge clk_i) disable iff (!arst_n_i)
		(out_req_o.q_valid && !out_rsp_i.q_ready) |=>
		(out_req_o.q_valid && $stable(out_req_o.q)));

endmodule

// File: hdl/strb_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Shared widths and bus structs for the partial-write subsystem
// Addresses are word addresses, not byte addresses
// user.port must match the requester port the request enters on
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package strb_pkg;

	// Data word width in bits
	localparam int unsigned data_width_c = 32;
	// One strobe bit per byte lane
	localparam int unsigned strb_width_c = data_width_c / 8;
	// Word address, 64 words in the store
	localparam int unsigned addr_width_c = 6;
	localparam int unsigned mem_depth_c = 2 ** addr_width_c;
	// Transaction tag picked by the requester
	localparam int unsigned tag_width_c = 3;

	// Routing and tracking info, echoed back in every response
	typedef struct packed {
		logic port;
		logic [tag_width_c-1:0] tag;
	} user_t;

	// Request payload
	typedef struct packed {
		logic [addr_width_c-1:0] addr;
		logic write;
		logic [data_width_c-1:0] data;
		logic [strb_width_c-1:0] strb;
		user_t user;
	} req_payload_t;

	// Response payload, read data or the written word
	typedef struct packed {
		logic [data_width_c-1:0] data;
		user_t user;
	} rsp_payload_t;

	// Travels toward the store
	typedef struct packed {
		req_payload_t q;
		logic q_valid;
		logic p_ready;
	} mem_req_t;

	// Travels back from the store
	typedef struct packed {
		rsp_payload_t p;
		logic p_valid;
		logic q_ready;
	} mem_rsp_t;

endpackage

// File: hdl/strb_subsys_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Two requester ports with partial-write handling over one store
// Requests on port N must carry user.port = N
// Concurrent RMW on one word from both ports is undefined
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns

module strb_subsys_top (
	input logic clk_i,
	input logic arst_n_i,
	input strb_pkg::mem_req_t req0_i,
	input strb_pkg::mem_req_t req1_i,
	output strb_pkg::mem_rsp_t rsp0_o,
	output strb_pkg::mem_rsp_t rsp1_o
);

	// Handler outputs toward the arbiter
	strb_pkg::mem_req_t hdl0_req, hdl1_req;
	logic hdl0_rsp_ready, hdl1_rsp_ready;

	// Arbiter inputs, p_ready taken from the handler
	strb_pkg::mem_req_t arb0_req, arb1_req;
	strb_pkg::mem_rsp_t arb0_rsp, arb1_rsp;

	// Store side
	strb_pkg::mem_req_t mem_req;
	strb_pkg::mem_rsp_t mem_rsp;

	strbreq_handler u_hdl0 (
		.clk_i (clk_i),
		.arst_n_i (arst_n_i),
		.strb_req_i (req0_i),
		.strb_rsp_ready_i (req0_i.p_ready),
		.strb_rsp_i (arb0_rsp),
		.strb_req_o (hdl0_req),
		.strb_rsp_ready_o (hdl0_rsp_ready),
		.strb_rsp_o (rsp0_o)
	);

	strbreq_handler u_hdl1 (
		.clk_i (clk_i),
		.arst_n_i (arst_n_i),
		.strb_req_i (req1_i),
		.strb_rsp_ready_i (req1_i.p_ready),
		.strb_rsp_i (arb1_rsp),
		.strb_req_o (hdl1_req),
		.strb_rsp_ready_o (hdl1_rsp_ready),
		.strb_rsp_o (rsp1_o)
	);

	// Handler may swallow a response, so its own ready is used here
	assign arb0_req = '{q: hdl0_req.q, q_valid: hdl0_req.q_valid, p_ready: hdl0_rsp_ready};
	assign arb1_req = '{q: hdl1_req.q, q_valid: hdl1_req.q_valid, p_ready: hdl1_rsp_ready};

	reqrsp_arbiter u_arb (
		.clk_i (clk_i),
		.arst_n_i (arst_n_i),
		.in0_req_i (arb0_req),
		.in1_req_i (arb1_req),
		.in0_rsp_o (arb0_rsp),
		.in1_rsp_o (arb1_rsp),
		.out_req_o (mem_req),
		.out_rsp_i (mem_rsp)
	);

	word_mem u_mem (
		.clk_i (clk_i),
		.arst_n_i (arst_n_i),
		.mem_req_i (mem_req),
		.mem_rsp_o (mem_rsp)
	);

endmodule

// File: hdl/strbreq_handler.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Expands a partial write into a full-word read plus merged full write
// Reads and full writes pass through with no added latency
// Requester must hold its request stable until q_ready
// Store side answers in request order
// No atomicity against other ports touching the same word
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns

module strbreq_handler (
	input logic clk_i,
	input logic arst_n_i,
	// Request from the requester before strobe handling
	input strb_pkg::mem_req_t strb_req_i,
	// Response ready from the requester
	input logic strb_rsp_ready_i,
	// Response and request ready from the store
	input strb_pkg::mem_rsp_t strb_rsp_i,
	// Request toward the store after strobe handling
	output strb_pkg::mem_req_t strb_req_o,
	// Response ready toward the store
	output logic strb_rsp_ready_o,
	// Response toward the requester
	output strb_pkg::mem_rsp_t strb_rsp_o
);

	typedef enum logic [1:0] {
		fsm_init_read,
		fsm_read_wait,
		fsm_write,
		fsm_write_wait
	} strb_state_e;

	strb_state_e state_d, state_q;

	// Old word from the inserted read
	logic [strb_pkg::data_width_c-1:0] rd_data_d, rd_data_q;
	// Word after byte merge
	logic [strb_pkg::data_width_c-1:0] merged_data;

	logic is_partial;
	logic rsp_match;
	logic rsp_swallow;

	// Write with any strobe bit clear
	assign is_partial = strb_req_i.q.write && (strb_req_i.q.strb != '1);

	// Inserted read comes back with the same user field as the request
	assign rsp_match = strb_rsp_i.p_valid && (strb_rsp_i.p.user == strb_req_i.q.user);

	// Response accepted from the store but hidden from the requester
	assign rsp_swallow = strb_rsp_i.p_valid && strb_rsp_ready_o && !strb_rsp_o.p_valid;

	always_comb begin
		state_d = state_q;
		rd_data_d = rd_data_q;

		// Pass-through by default
		strb_req_o = strb_req_i;
		strb_req_o.q.data = merged_data;
		strb_rsp_ready_o = strb_rsp_ready_i;
		strb_rsp_o = strb_rsp_i;

		case (state_q)
			fsm_init_read: begin
				if (strb_req_i.q_valid && is_partial) begin
					// Hold off the requester
					strb_rsp_o.q_ready = 1'b0;
					// Issue a full-word read instead
					strb_req_o.q_valid = 1'b1;
					strb_req_o.q.write = 1'b0;
					strb_req_o.q.strb = '1;
					if (strb_rsp_i.q_ready) begin
						state_d = fsm_write;
					end else begin
						state_d = fsm_read_wait;
					end
				end
			end
			fsm_read_wait: begin
				// Keep the read up while it is stalled
				strb_rsp_o.q_ready = 1'b0;
				strb_req_o.q_valid = 1'b1;
				strb_req_o.q.write = 1'b0;
				strb_req_o.q.strb = '1;
				if (strb_rsp_i.q_ready) begin
					state_d = fsm_write;
				end
			end
			fsm_write: begin
				// Nothing goes out until the read data is back
				strb_rsp_o.q_ready = 1'b0;
				strb_req_o.q_valid = 1'b0;
				if (rsp_match) begin
					// Take the read response and hide it from the requester
					strb_rsp_ready_o = 1'b1;
					strb_rsp_o.p_valid = 1'b0;
					rd_data_d = strb_rsp_i.p.data;
					// Merged full write goes out in the same cycle
					strb_req_o.q_valid = 1'b1;
					strb_req_o.q.write = 1'b1;
					strb_req_o.q.strb = '1;
					// Requester request completes with the merged write
					strb_rsp_o.q_ready = strb_rsp_i.q_ready;
					if (strb_rsp_i.q_ready) begin
						state_d = fsm_init_read;
					end else begin
						state_d = fsm_write_wait;
					end
				end
			end
			fsm_write_wait: begin
				// Merged write is stalled and q_ready passes straight back
				strb_req_o.q_valid = 1'b1;
				strb_req_o.q.write = 1'b1;
				strb_req_o.q.strb = '1;
				if (strb_rsp_i.q_ready) begin
					state_d = fsm_init_read;
				end
			end
			default: begin
				state_d = fsm_init_read;
			end
		endcase
	end

	// Per byte lane the new byte where the strobe is set and the old byte otherwise
	// For a full write this is just the request data
	for (genvar i = 0; i < strb_pkg::strb_width_c; i++) begin : gen_byte_mux
		assign merged_data[i*8 +: 8] = strb_req_i.q.strb[i] ?
			strb_req_i.q.data[i*8 +: 8] : rd_data_d[i*8 +: 8];
	end

	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			state_q <= fsm_init_read;
		end else begin
			state_q <= state_d;
		end
	end

	always_ff @(posedge clk_i) begin
		rd_data_q <= rd_data_d;
	end

	// Requester holds the partial write while it is being expanded
	assert property (@(posedge clk_i) disable iff (!arst_n_i)
		(state_q != fsm_init_read) |-> (strb_req_i.q_valid && $stable(strb_req_i.q)));

	// The only response seen in Write is the inserted read and it gets swallowed
	assert property (@(posedge clk_i) disable iff (!arst_n_i)
		(state_q == fsm_write && strb_rsp_i.p_valid) |-> rsp_swallow);

endmodule

// File: hdl/word_mem.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Word store that ignores byte strobes
// One-cycle response, one response register, no bypass
// Every write overwrites the full word
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns

module word_mem (
	input logic clk_i,
	input logic arst_n_i,
	input strb_pkg::mem_req_t mem_req_i,
	output strb_pkg::mem_rsp_t mem_rsp_o
);

	logic [strb_pkg::data_width_c-1:0] mem_q [strb_pkg::mem_depth_c];

	// Response register
	strb_pkg::rsp_payload_t rsp_q;
	logic rsp_valid_q;

	logic req_xfer;

	// Ready when the register is free or drains this cycle
	assign mem_rsp_o.q_ready = !rsp_valid_q || mem_req_i.p_ready;
	assign req_xfer = mem_req_i.q_valid && mem_rsp_o.q_ready;

	assign mem_rsp_o.p = rsp_q;
	assign mem_rsp_o.p_valid = rsp_valid_q;

	// Store array, cleared on reset so unwritten words read as zero
	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			for (int i = 0; i < strb_pkg::mem_depth_c; i++) begin
				mem_q[i] <= '0;
			end
		end else if (req_xfer && mem_req_i.q.write) begin
			mem_q[mem_req_i.q.addr] <= mem_req_i.q.data;
		end
	end

	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			rsp_valid_q <= 1'b0;
		end else if (req_xfer) begin
			rsp_valid_q <= 1'b1;
		end else if (mem_req_i.p_ready) begin
			rsp_valid_q <= 1'b0;
		end
	end

	// Write echoes its data, read returns the old word
	always_ff @(posedge clk_i) begin
		if (req_xfer) begin
			rsp_q.user <= mem_req_i.q.user;
			rsp_q.data <= mem_req_i.q.write ? mem_req_i.q.data : mem_q[mem_req_i.q.addr];
		end
	end

	// Partial writes must have been expanded upstream
	assert property (@(posedge clk_i) disable iff (!arst_n_i)
		(mem_req_i.q_valid && mem_req_i.q.write) |-> (mem_req_i.q.strb == '1));

endmodule

// File: tb/strb_tests.txt
# group port write addr strb data expected, all hex
# expected is the read word, or the merged word a write stores and returns
00 0 0 05 f 00000000 00000000
00 1 0 06 f 00000000 00000000
01 0 1 01 f 11223344 11223344
02 0 0 01 f 00000000 11223344
03 1 1 02 f aabbccdd aabbccdd
04 1 0 02 f 00000000 aabbccdd
05 0 1 01 5 55667788 11663388
06 0 0 01 f 00000000 11663388
07 1 1 02 a 12345678 12bb56dd
08 1 0 02 f 00000000 12bb56dd
09 0 1 01 0 ffffffff 11663388
0a 0 0 01 f 00000000 11663388
0b 0 1 01 3 0000cafe 1166cafe
0b 1 1 02 c beef0000 beef56dd
0c 0 0 01 f 00000000 1166cafe
0c 1 0 02 f 00000000 beef56dd
0d 0 1 10 f 0badf00d 0badf00d
0d 1 1 11 f 600dcafe 600dcafe
0e 0 1 10 8 7f000000 7fadf00d
0e 1 1 11 1 000000ee 600dcaee
0f 0 0 11 f 00000000 600dcaee
0f 1 0 10 f 00000000 7fadf00d
10 1 1 3f 6 00abcd00 00abcd00
10 0 0 20 f 00000000 00000000
11 0 0 3f f 00000000 00abcd00
11 1 1 01 0 00000000 1166cafe
12 1 0 01 f 00000000 1166cafe

// File: tb/tb_clkgen.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// 20 ns clock, reset held low for 8 rising edges
// Reset is released 2 ns after an edge, like every other input
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns

module tb_clkgen (
	output logic clk_o,
	output logic arst_n_o
);

	localparam int unsigned half_period_c = 10;
	localparam int unsigned reset_cycles_c = 8;

	initial begin
		clk_o = 1'b0;
		forever #half_period_c clk_o = ~clk_o;
	end

	initial begin
		arst_n_o = 1'b0;
		repeat (reset_cycles_c) @(posedge clk_o);
		#2 arst_n_o = 1'b1;
	end

endmodule

// File: tb/tb_strb_subsys.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Runs tb/strb_tests.txt with the project root as working folder
// Commands of one group start together on both ports
// Both ports must never RMW the same word in one group
// Stops at the first mismatch or timeout
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns

module tb_strb_subsys;

	localparam int unsigned timeout_c = 200;
	localparam int unsigned drive_delay_c = 2;
	localparam string tests_file_c = "tb/strb_tests.txt";

	// One line of the test file
	typedef struct packed {
		logic [7:0] group;
		logic port;
		logic write;
		logic [strb_pkg::addr_width_c-1:0] addr;
		logic [strb_pkg::strb_width_c-1:0] strb;
		logic [strb_pkg::data_width_c-1:0] data;
		logic [strb_pkg::data_width_c-1:0] exp;
	} cmd_t;

	logic clk;
	logic arst_n;
	strb_pkg::req_payload_t q_pl [2];
	logic q_valid [2];
	logic p_ready [2];
	strb_pkg::mem_req_t req [2];
	strb_pkg::mem_rsp_t rsp [2];
	// Request issued and response not yet taken
	logic busy [2];
	// Response was stalled at the last sample
	logic held [2];
	strb_pkg::rsp_payload_t held_p [2];
	logic [15:0] lfsr;
	cmd_t cmds [$];
	int unsigned rsp_count;

	tb_clkgen u_clkgen (
		.clk_o (clk),
		.arst_n_o (arst_n)
	);

	assign req[0] = '{q: q_pl[0], q_valid: q_valid[0], p_ready: p_ready[0]};
	assign req[1] = '{q: q_pl[1], q_valid: q_valid[1], p_ready: p_ready[1]};

	strb_subsys_top dut (
		.clk_i (clk),
		.arst_n_i (arst_n),
		.req0_i (req[0]),
		.req1_i (req[1]),
		.rsp0_o (rsp[0]),
		.rsp1_o (rsp[1])
	);

	task automatic fail_run(input string msg);
		$display("%s", msg);
		$display("Done: errors found");
		$fatal(1);
	endtask

	// x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] step_lfsr(input logic [15:0] s);
		logic fb;
		fb = s[15] ^ s[13] ^ s[12] ^ s[10];
		return {s[14:0], fb};
	endfunction

	task automatic read_tests();
		int fd;
		int n;
		string line;
		logic [31:0] g, pt, wr, ad, st, dt, ex;
		cmd_t c;
		fd = $fopen(tests_file_c, "r");
		assert (fd != 0) else fail_run("Cannot open the test file");
		while (!$feof(fd)) begin
			line = "";
			n = $fgets(line, fd);
			// Comment lines are skipped and blank lines give no fields
			if (n > 0 && line.getc(0) != "#") begin
				n = $sscanf(line, "%h %h %h %h %h %h %h", g, pt, wr, ad, st, dt, ex);
				if (n == 7) begin
					c = '{group: g[7:0], port: pt[0], write: wr[0],
						addr: ad[strb_pkg::addr_width_c-1:0],
						strb: st[strb_pkg::strb_width_c-1:0], data: dt, exp: ex};
					cmds.push_back(c);
				end else if (n > 0) begin
					fail_run({"Malformed line in the test file: ", line});
				end
			end
		end
		$fclose(fd);
		assert (cmds.size() > 0) else fail_run("The test file holds no commands");
	endtask

	// One command on one port with its request and then its response
	task automatic run_command(input int p, input int i);
		cmd_t c;
		logic [strb_pkg::tag_width_c-1:0] tag;
		strb_pkg::rsp_payload_t got;
		int unsigned waited;
		logic done;
		c = cmds[i];
		// Tag from the line index makes a stray response show up
		tag = i[strb_pkg::tag_width_c-1:0];
		q_pl[p] = '{addr: c.addr, write: c.write, data: c.data, strb: c.strb,
			user: '{port: c.port, tag: tag}};
		q_valid[p] = 1'b1;
		busy[p] = 1'b1;
		waited = 0;
		done = 1'b0;
		while (!done) begin
			@(negedge clk);
			// Swallowed read must stay hidden
			assert (!rsp[p].p_valid) else begin
				fail_run($sformatf("Port %0d got a response before its request was taken", p));
			end
			done = rsp[p].q_ready;
			waited++;
			if (!done && waited >= timeout_c) begin
				fail_run($sformatf("Timeout waiting for the request on port %0d to be taken", p));
			end
			@(posedge clk);
			#drive_delay_c;
		end
		q_valid[p] = 1'b0;
		waited = 0;
		done = 1'b0;
		while (!done) begin
			@(negedge clk);
			done = rsp[p].p_valid && p_ready[p];
			got = rsp[p].p;
			waited++;
			if (!done && waited >= timeout_c) begin
				fail_run($sformatf("Timeout waiting for the response on port %0d", p));
			end
			@(posedge clk);
			#drive_delay_c;
		end
		assert (got.data == c.exp) else begin
			fail_run($sformatf("ERROR rsp%0d_o.p.data expected %h actual %h", p, c.exp, got.data));
		end
		assert (got.user.port == c.port) else begin
			fail_run($sformatf("ERROR rsp%0d_o.p.user.port expected %h actual %h",
				p, c.port, got.user.port));
		end
		assert (got.user.tag == tag) else begin
			fail_run($sformatf("ERROR rsp%0d_o.p.user.tag expected %h actual %h",
				p, tag, got.user.tag));
		end
		busy[p] = 1'b0;
		rsp_count++;
	endtask

	// Commands of this port from one group in file order
	task automatic run_port(input int p, input int first, input int last);
		for (int i = first; i < last; i++) begin
			if (int'(cmds[i].port) == p) begin
				run_command(p, i);
			end
		end
	endtask

	// Random response back-pressure with one LFSR step per port and cycle
	initial begin
		lfsr = 16'd27;
		p_ready[0] = 1'b0;
		p_ready[1] = 1'b0;
		forever begin
			@(posedge clk);
			#drive_delay_c;
			for (int p = 0; p < 2; p++) begin
				lfsr = step_lfsr(lfsr);
				p_ready[p] = lfsr[0];
			end
		end
	end

	// No response without a request and stalled responses hold still
	always @(negedge clk) begin
		for (int p = 0; p < 2; p++) begin
			if (!arst_n) begin
				held[p] = 1'b0;
			end else begin
				assert (!rsp[p].p_valid || busy[p]) else begin
					fail_run($sformatf("Response on port %0d with no request outstanding", p));
				end
				if (held[p]) begin
					assert (rsp[p].p_valid) else begin
						fail_run($sformatf("Response on port %0d dropped before its transfer", p));
					end
					assert (rsp[p].p == held_p[p]) else begin
						fail_run($sformatf("ERROR rsp%0d_o.p expected %h actual %h",
							p, held_p[p], rsp[p].p));
					end
				end
				held[p] = rsp[p].p_valid && !p_ready[p];
				held_p[p] = rsp[p].p;
			end
		end
	end

	initial begin
		int unsigned waited;
		int first;
		int last;
		for (int p = 0; p < 2; p++) begin
			q_pl[p] = '0;
			q_valid[p] = 1'b0;
			busy[p] = 1'b0;
		end
		rsp_count = 0;
		read_tests();
		waited = 0;
		while (!arst_n) begin
			@(posedge clk);
			waited++;
			if (waited > timeout_c) begin
				fail_run("Reset was never released");
			end
		end
		// Nothing pending right after reset
		@(negedge clk);
		assert (!rsp[0].p_valid && !rsp[1].p_valid) else begin
			fail_run("Response valid right after reset");
		end
		@(posedge clk);
		#drive_delay_c;
		first = 0;
		while (first < cmds.size()) begin
			last = first;
			while (last < cmds.size() && cmds[last].group == cmds[first].group) begin
				last++;
			end
			fork
				run_port(0, first, last);
				run_port(1, first, last);
			join
			first = last;
		end
		$display("Checked %0d responses", rsp_count);
		$display("Done: no errors");
		$finish;
	end

endmodule
